/* verilog/blit_pkg.sv */
package blit_pkg;

typedef logic [15:0] word_t;        // video memory data word
typedef logic [15:0] addr_t;        // video memory word address
typedef logic [3:0]  reg_num_t;     // config register number
typedef logic [3:0]  nib_mask_t;    // one write enable per nibble

localparam reg_num_t REG_CTRL  = 4'd0;
localparam reg_num_t REG_SHIFT = 4'd1;
localparam reg_num_t REG_MOD_A = 4'd2;
localparam reg_num_t REG_SRC_A = 4'd3;
localparam reg_num_t REG_MOD_B = 4'd4;
localparam reg_num_t REG_SRC_B = 4'd5;
localparam reg_num_t REG_VAL_C = 4'd6;
localparam reg_num_t REG_MOD_D = 4'd7;
localparam reg_num_t REG_DST_D = 4'd8;
localparam reg_num_t REG_LINES = 4'd9;      // number of lines
localparam reg_num_t REG_WORDS = 4'd10;     // words per line, write queues the blit

typedef struct packed {
    logic [7:0] transp_t;           // transparency byte T
    logic [1:0] rsvd_hi;
    logic       transp_8b;          // test byte pairs instead of nibbles
    logic       rsvd;
    logic       c_use_b;            // B takes the place of C
    logic       b_not;              // invert B in the logic op
    logic       b_const;            // B comes from SRC_B, no read
    logic       a_const;            // A comes from SRC_A, no read
} blit_ctrl_t;

typedef struct packed {
    logic [3:0] l_mask;             // nibble mask on first word of a line
    logic [3:0] r_mask;             // nibble mask on last word of a line
    logic [5:0] rsvd;
    logic [1:0] count;              // right shift in nibbles
} blit_shift_t;

typedef union packed {
    blit_ctrl_t  ctrl;
    blit_shift_t shift;
} ctrl_word_u;

endpackage

/* verilog/blit_regs.sv */
`timescale 1ns/1ps

module blit_regs #(
    parameter int LINES_W = 15
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 xreg_wr_en_i,
    input  blit_pkg::reg_num_t   xreg_num_i,
    input  blit_pkg::word_t      xreg_data_i,
    input  logic                 take_i,         // sequencer copies the queued blit
    output logic                 queued_o,
    output blit_pkg::ctrl_word_u ctrl_o,
    output blit_pkg::ctrl_word_u shift_o,
    output blit_pkg::word_t      mod_a_o,
    output blit_pkg::addr_t      src_a_o,
    output blit_pkg::word_t      mod_b_o,
    output blit_pkg::addr_t      src_b_o,
    output blit_pkg::word_t      val_c_o,
    output blit_pkg::word_t      mod_d_o,
    output blit_pkg::addr_t      dst_d_o,
    output logic [LINES_W-1:0]   lines_o,
    output blit_pkg::word_t      words_o
);

    import blit_pkg::*;

    logic wr_words;

    assign wr_words = xreg_wr_en_i && (xreg_num_i == REG_WORDS);

    // one-deep queue, a new WORDS write wins over take
    always_ff @(posedge clk) begin
        if (reset_i) begin
            queued_o <= 1'b0;
        end else if (wr_words) begin
            queued_o <= 1'b1;
        end else if (take_i) begin
            queued_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xreg_wr_en_i) begin
            case (xreg_num_i)
                REG_CTRL: begin
                    ctrl_o <= xreg_data_i;
                end
                REG_SHIFT: begin
                    shift_o <= xreg_data_i;
                end
                REG_MOD_A: begin
                    mod_a_o <= xreg_data_i;
                end
                REG_SRC_A: begin
                    src_a_o <= xreg_data_i;
                end
                REG_MOD_B: begin
                    mod_b_o <= xreg_data_i;
                end
                REG_SRC_B: begin
                    src_b_o <= xreg_data_i;
                end
                REG_VAL_C: begin
                    val_c_o <= xreg_data_i;
                end
                REG_MOD_D: begin
                    mod_d_o <= xreg_data_i;
                end
                REG_DST_D: begin
                    dst_d_o <= xreg_data_i;
                end
                REG_LINES: begin
                    lines_o <= xreg_data_i[LINES_W-1:0];
                end
                REG_WORDS: begin
                    words_o <= xreg_data_i;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* verilog/blit_nibble_shift.sv */
`timescale 1ns/1ps

module blit_nibble_shift (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 setup_i,        // latch shift count
    input  logic                 line_start_i,   // clear spill
    input  logic                 load_i,         // read data accepted
    input  blit_pkg::ctrl_word_u shift_i,
    input  blit_pkg::word_t      data_i,
    output blit_pkg::word_t      shifted_o
);

    logic [1:0]  count_q;
    logic [11:0] spill_q;           // nibbles left over from previous word, top aligned
    logic [27:0] wide;              // shifted word above nibbles shifted out

    always_comb begin
        case (count_q)
            2'd0:    wide = {data_i, 12'h000};
            2'd1:    wide = {spill_q[11:8], data_i, 8'h00};
            2'd2:    wide = {spill_q[11:4], data_i, 4'h0};
            default: wide = {spill_q, data_i};
        endcase
    end

    assign shifted_o = wide[27:12];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= 2'd0;
            spill_q <= 12'h000;
        end else begin
            if (setup_i) begin
                count_q <= shift_i.shift.count;
            end
            if (line_start_i) begin
                spill_q <= 12'h000;         // no carry across lines
            end else if (load_i) begin
                spill_q <= wide[11:0];
            end
        end
    end

endmodule

/* verilog/blit_datapath.sv */
`timescale 1ns/1ps

module blit_datapath (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 setup_i,
    input  logic                 load_a_i,
    input  logic                 load_b_i,
    input  logic                 first_word_i,
    input  logic                 last_word_i,
    input  blit_pkg::ctrl_word_u ctrl_i,
    input  blit_pkg::ctrl_word_u shift_i,
    input  blit_pkg::word_t      src_a_i,
    input  blit_pkg::word_t      src_b_i,
    input  blit_pkg::word_t      val_c_i,
    input  blit_pkg::word_t      shifted_a_i,
    input  blit_pkg::word_t      shifted_b_i,
    output blit_pkg::word_t      data_o,
    output blit_pkg::nib_mask_t  wr_mask_o
);

    import blit_pkg::*;

    logic      b_not_q;
    logic      c_use_b_q;
    logic      transp_8b_q;
    logic [7:0] transp_t_q;
    nib_mask_t l_mask_q;
    nib_mask_t r_mask_q;
    word_t     val_a_q;
    word_t     val_b_q;
    word_t     val_c_q;
    word_t     val_t;               // zero where B matches T
    nib_mask_t transp_mask;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            b_not_q     <= 1'b0;
            c_use_b_q   <= 1'b0;
            transp_8b_q <= 1'b0;
            l_mask_q    <= '0;
            r_mask_q    <= '0;
        end else if (setup_i) begin
            b_not_q     <= ctrl_i.ctrl.b_not;
            c_use_b_q   <= ctrl_i.ctrl.c_use_b;
            transp_8b_q <= ctrl_i.ctrl.transp_8b;
            l_mask_q    <= shift_i.shift.l_mask;
            r_mask_q    <= shift_i.shift.r_mask;
        end
    end

    // operand values, constants preloaded on setup
    always_ff @(posedge clk) begin
        if (setup_i) begin
            transp_t_q <= ctrl_i.ctrl.transp_t;
            val_c_q    <= val_c_i;
            val_a_q    <= src_a_i;
            val_b_q    <= src_b_i;
        end else begin
            if (load_a_i) begin
                val_a_q <= shifted_a_i;
            end
            if (load_b_i) begin
                val_b_q <= shifted_b_i;
            end
        end
    end

    assign data_o = (val_a_q & (b_not_q ? ~val_b_q : val_b_q)) ^ (c_use_b_q ? val_b_q : val_c_q);

    assign val_t = val_b_q ^ {transp_t_q, transp_t_q};

    always_comb begin
        if (transp_8b_q) begin
            transp_mask = {{2{|val_t[15:8]}}, {2{|val_t[7:0]}}};     // byte pairs
        end else begin
            transp_mask = {|val_t[15:12], |val_t[11:8], |val_t[7:4], |val_t[3:0]};
        end
    end

    assign wr_mask_o = transp_mask
                     & (first_word_i ? l_mask_q : 4'hf)
                     & (last_word_i  ? r_mask_q : 4'hf);

endmodule

/* verilog/blit_sequencer.sv */
`timescale 1ns/1ps

module blit_sequencer #(
    parameter int LINES_W = 15
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 queued_i,
    input  blit_pkg::ctrl_word_u ctrl_i,
    input  blit_pkg::word_t      mod_a_i,
    input  blit_pkg::word_t      mod_b_i,
    input  blit_pkg::word_t      mod_d_i,
    input  blit_pkg::addr_t      src_a_i,
    input  blit_pkg::addr_t      src_b_i,
    input  blit_pkg::addr_t      dst_d_i,
    input  logic [LINES_W-1:0]   lines_i,
    input  blit_pkg::word_t      words_i,
    input  logic                 vram_ack_i,
    output logic                 take_o,
    output logic                 setup_o,
    output logic                 line_start_o,
    output logic                 load_a_o,
    output logic                 load_b_o,
    output logic                 first_word_o,
    output logic                 last_word_o,
    output logic                 busy_o,
    output logic                 done_o,
    output logic                 vram_sel_o,
    output logic                 vram_wr_o,
    output blit_pkg::addr_t      vram_addr_o
);

    import blit_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        LINE_BEG,
        WAIT_RD_A,
        WAIT_RD_B,
        WAIT_WR_D,
        LINE_END
    } state_t;

    state_t         state;
    logic           a_const_q;
    logic           b_const_q;
    word_t          mod_a_q;
    word_t          mod_b_q;
    word_t          mod_d_q;
    addr_t          src_a_q;
    addr_t          src_b_q;
    addr_t          dst_d_q;
    word_t          words_q;
    logic [16:0]    count_q;        // top bit set on last word of line
    logic [LINES_W:0] lines_q;      // top bit set on last line
    logic           ack;
    logic           both_const;
    state_t         word_state;     // first access of a word
    addr_t          word_addr;

    assign ack        = vram_ack_i && vram_sel_o;
    assign both_const = a_const_q && b_const_q;
    assign word_state = !a_const_q ? WAIT_RD_A : (!b_const_q ? WAIT_RD_B : WAIT_WR_D);
    assign word_addr  = !a_const_q ? src_a_q : (!b_const_q ? src_b_q : dst_d_q);

    assign take_o       = (state == SETUP);
    assign setup_o      = (state == SETUP);
    assign line_start_o = (state == LINE_BEG);
    assign load_a_o     = (state == WAIT_RD_A) && ack;
    assign load_b_o     = (state == WAIT_RD_B) && ack;
    assign last_word_o  = count_q[16];
    assign busy_o       = (state != IDLE);
    assign done_o       = (state == LINE_END) && lines_q[LINES_W];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= IDLE;
            vram_sel_o   <= 1'b0;
            vram_wr_o    <= 1'b0;
            first_word_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (queued_i) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    a_const_q <= ctrl_i.ctrl.a_const;
                    b_const_q <= ctrl_i.ctrl.b_const;
                    mod_a_q   <= mod_a_i;
                    mod_b_q   <= mod_b_i;
                    mod_d_q   <= mod_d_i;
                    src_a_q   <= src_a_i;
                    src_b_q   <= src_b_i;
                    dst_d_q   <= dst_d_i;
                    words_q   <= words_i;
                    lines_q   <= {1'b0, lines_i} - 1'b1;
                    state     <= LINE_BEG;
                end
                LINE_BEG: begin
                    lines_q      <= lines_q - 1'b1;
                    count_q      <= {1'b0, words_q} - 17'd2;  // underflows on the last word
                    first_word_o <= 1'b1;
                    vram_sel_o   <= 1'b1;
                    vram_wr_o    <= both_const;
                    vram_addr_o  <= word_addr;
                    state        <= word_state;
                end
                WAIT_RD_A: begin
                    if (ack) begin
                        src_a_q     <= src_a_q + 1'b1;
                        vram_wr_o   <= b_const_q;
                        vram_addr_o <= b_const_q ? dst_d_q : src_b_q;
                        state       <= b_const_q ? WAIT_WR_D : WAIT_RD_B;
                    end
                end
                WAIT_RD_B: begin
                    if (ack) begin
                        src_b_q     <= src_b_q + 1'b1;
                        vram_wr_o   <= 1'b1;
                        vram_addr_o <= dst_d_q;
                        state       <= WAIT_WR_D;
                    end
                end
                WAIT_WR_D: begin
                    if (ack) begin
                        dst_d_q      <= dst_d_q + 1'b1;
                        count_q      <= count_q - 1'b1;
                        first_word_o <= 1'b0;
                        if (last_word_o) begin
                            vram_sel_o <= 1'b0;
                            vram_wr_o  <= 1'b0;
                            state      <= LINE_END;
                        end else begin
                            vram_wr_o   <= both_const;
                            vram_addr_o <= both_const ? dst_d_q + 1'b1 : word_addr;
                            state       <= word_state;
                        end
                    end
                end
                LINE_END: begin
                    src_a_q <= src_a_q + mod_a_q;
                    src_b_q <= src_b_q + mod_b_q;
                    dst_d_q <= dst_d_q + mod_d_q;
                    if (!lines_q[LINES_W]) begin
                        state <= LINE_BEG;
                    end else if (queued_i) begin
                        state <= SETUP;             // queued blit follows directly
                    end else begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/blitter.sv */
`timescale 1ns/1ps

module blitter #(
    parameter int LINES_W = 15
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                xreg_wr_en_i,
    input  blit_pkg::reg_num_t  xreg_num_i,
    input  blit_pkg::word_t     xreg_data_i,
    output logic                blit_busy_o,
    output logic                blit_full_o,
    output logic                blit_done_intr_o,
    output logic                blit_vram_sel_o,
    input  logic                blit_vram_ack_i,
    output logic                blit_wr_o,
    output blit_pkg::nib_mask_t blit_wr_mask_o,
    output blit_pkg::addr_t     blit_addr_o,
    input  blit_pkg::word_t     blit_data_i,
    output blit_pkg::word_t     blit_data_o
);

    import blit_pkg::*;

    ctrl_word_u         ctrl;
    ctrl_word_u         shift;
    word_t              mod_a;
    word_t              mod_b;
    word_t              mod_d;
    addr_t              src_a;
    addr_t              src_b;
    addr_t              dst_d;
    word_t              val_c;
    logic [LINES_W-1:0] lines;
    word_t              words;
    logic               take;
    logic               setup;
    logic               line_start;
    logic               load_a;
    logic               load_b;
    logic               first_word;
    logic               last_word;
    word_t              shifted_a;
    word_t              shifted_b;

    blit_regs #(.LINES_W(LINES_W)) u_regs (
        .clk, .reset_i, .xreg_wr_en_i, .xreg_num_i, .xreg_data_i,
        .take_i(take), .queued_o(blit_full_o), .ctrl_o(ctrl), .shift_o(shift),
        .mod_a_o(mod_a), .src_a_o(src_a), .mod_b_o(mod_b), .src_b_o(src_b),
        .val_c_o(val_c), .mod_d_o(mod_d), .dst_d_o(dst_d),
        .lines_o(lines), .words_o(words)
    );

    blit_sequencer #(.LINES_W(LINES_W)) u_seq (
        .clk, .reset_i, .queued_i(blit_full_o), .ctrl_i(ctrl),
        .mod_a_i(mod_a), .mod_b_i(mod_b), .mod_d_i(mod_d),
        .src_a_i(src_a), .src_b_i(src_b), .dst_d_i(dst_d),
        .lines_i(lines), .words_i(words), .vram_ack_i(blit_vram_ack_i),
        .take_o(take), .setup_o(setup), .line_start_o(line_start),
        .load_a_o(load_a), .load_b_o(load_b),
        .first_word_o(first_word), .last_word_o(last_word),
        .busy_o(blit_busy_o), .done_o(blit_done_intr_o),
        .vram_sel_o(blit_vram_sel_o), .vram_wr_o(blit_wr_o), .vram_addr_o(blit_addr_o)
    );

    // one shifter per read source, both see the same memory data
    blit_nibble_shift u_shift_a (
        .clk, .reset_i, .setup_i(setup), .line_start_i(line_start), .load_i(load_a),
        .shift_i(shift), .data_i(blit_data_i), .shifted_o(shifted_a)
    );

    blit_nibble_shift u_shift_b (
        .clk, .reset_i, .setup_i(setup), .line_start_i(line_start), .load_i(load_b),
        .shift_i(shift), .data_i(blit_data_i), .shifted_o(shifted_b)
    );

    blit_datapath u_dp (
        .clk, .reset_i, .setup_i(setup), .load_a_i(load_a), .load_b_i(load_b),
        .first_word_i(first_word), .last_word_i(last_word),
        .ctrl_i(ctrl), .shift_i(shift), .src_a_i(src_a), .src_b_i(src_b), .val_c_i(val_c),
        .shifted_a_i(shifted_a), .shifted_b_i(shifted_b),
        .data_o(blit_data_o), .wr_mask_o(blit_wr_mask_o)
    );

endmodule

/* test/blitter_chk.sv */
`timescale 1ns/1ps

module blitter_chk (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            sel_i,
    input  logic            ack_i,
    input  logic            wr_i,
    input  blit_pkg::addr_t addr_i,
    input  logic            done_i,
    input  logic            busy_i,
    input  logic            full_i
);

    // an access without ack keeps its strobe, address and direction
    assert property (@(posedge clk) disable iff (reset_i)
        sel_i && !ack_i |=> sel_i && $stable(addr_i) && $stable(wr_i))
        else $error("memory access changed before it was acknowledged");

    assert property (@(posedge clk) disable iff (reset_i)
        done_i |=> !done_i)
        else $error("done pulse longer than one cycle");

    // nothing queued, so the blitter goes idle
    assert property (@(posedge clk) disable iff (reset_i)
        done_i && !full_i |=> !busy_i)
        else $error("busy still high after the last blit ended");

endmodule

bind blitter blitter_chk u_chk (
    .clk(clk), .reset_i(reset_i), .sel_i(blit_vram_sel_o), .ack_i(blit_vram_ack_i),
    .wr_i(blit_wr_o), .addr_i(blit_addr_o), .done_i(blit_done_intr_o),
    .busy_i(blit_busy_o), .full_i(blit_full_o)
);

/* test/blitter_tb.sv */
`timescale 1ns/1ps

module blitter_tb;

    import blit_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int WORDS_TOTAL = 82;        // words written over all tests
    localparam int WAIT_LIMIT  = 5000;

    logic        clk;
    logic        reset_i;
    logic        xreg_wr_en;
    reg_num_t    xreg_num;
    word_t       xreg_data;
    logic        busy;
    logic        full;
    logic        done;
    logic        vram_sel;
    logic        vram_ack;
    logic        vram_wr;
    nib_mask_t   wr_mask;
    addr_t       vram_addr;
    word_t       vram_rdata;
    word_t       vram_wdata;

    word_t       mem [4096];
    word_t       ref_mem [4096];
    logic [31:0] lfsr_state;
    logic        in_txn;
    int          wait_left;
    int          done_count;
    int          errors;
    int          tests_run;
    int          tests_failed;

    ctrl_word_u  cfg_ctrl;
    ctrl_word_u  cfg_shift;
    word_t       cfg_src_a, cfg_mod_a, cfg_src_b, cfg_mod_b, cfg_val_c;
    word_t       cfg_dst_d, cfg_mod_d, cfg_lines, cfg_words;

    blitter #(.LINES_W(15)) u_dut (
        .clk, .reset_i, .xreg_wr_en_i(xreg_wr_en), .xreg_num_i(xreg_num),
        .xreg_data_i(xreg_data), .blit_busy_o(busy), .blit_full_o(full),
        .blit_done_intr_o(done), .blit_vram_sel_o(vram_sel), .blit_vram_ack_i(vram_ack),
        .blit_wr_o(vram_wr), .blit_wr_mask_o(wr_mask), .blit_addr_o(vram_addr),
        .blit_data_i(vram_rdata), .blit_data_o(vram_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // memory: random ack delay of 0 to 3 cycles, writes under the nibble mask
    always @(posedge clk) begin : vram_model
        logic [31:0] r;
        int n;
        #1;
        if (vram_ack) begin
            in_txn = 1'b0;                  // previous access taken at this edge
        end
        vram_ack = 1'b0;
        if (vram_sel && !in_txn) begin
            in_txn = 1'b1;
            draw_bits(2, r);
            wait_left = r[1:0];
        end
        if (vram_sel && in_txn) begin
            if (wait_left == 0) begin
                vram_ack = 1'b1;
                if (vram_wr) begin
                    for (n = 0; n < 4; n++) begin
                        if (wr_mask[n]) begin
                            mem[vram_addr[11:0]][4*n +: 4] = vram_wdata[4*n +: 4];
                        end
                    end
                end else begin
                    vram_rdata = mem[vram_addr[11:0]];
                end
            end else begin
                wait_left--;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset_i && done) begin
            done_count++;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic configure_blit(input word_t ctrl, input word_t shift, input word_t src_a,
                                  input word_t mod_a, input word_t src_b, input word_t mod_b,
                                  input word_t val_c, input word_t dst_d, input word_t mod_d,
                                  input word_t lines, input word_t words);
        cfg_ctrl  = ctrl;
        cfg_shift = shift;
        cfg_src_a = src_a;
        cfg_mod_a = mod_a;
        cfg_src_b = src_b;
        cfg_mod_b = mod_b;
        cfg_val_c = val_c;
        cfg_dst_d = dst_d;
        cfg_mod_d = mod_d;
        cfg_lines = lines;
        cfg_words = words;
    endtask

    task automatic write_reg(input reg_num_t num, input word_t data);
        xreg_wr_en = 1'b1;
        xreg_num   = num;
        xreg_data  = data;
        @(posedge clk);
        #1;
        xreg_wr_en = 1'b0;
    endtask

    task automatic start_blit();
        @(posedge clk);
        #1;
        write_reg(REG_CTRL, cfg_ctrl);
        write_reg(REG_SHIFT, cfg_shift);
        write_reg(REG_MOD_A, cfg_mod_a);
        write_reg(REG_SRC_A, cfg_src_a);
        write_reg(REG_MOD_B, cfg_mod_b);
        write_reg(REG_SRC_B, cfg_src_b);
        write_reg(REG_VAL_C, cfg_val_c);
        write_reg(REG_MOD_D, cfg_mod_d);
        write_reg(REG_DST_D, cfg_dst_d);
        write_reg(REG_LINES, cfg_lines);
        write_reg(REG_WORDS, cfg_words);    // queues the blit
    endtask

    // expected result worked out line by line on ref_mem
    task automatic model_blit();
        addr_t pa, pb, pd;
        word_t ra, rb, prev_a, prev_b, a, b, d;
        logic  keep;
        int    ln, w, n, sh;
        pa = cfg_src_a;
        pb = cfg_src_b;
        pd = cfg_dst_d;
        sh = cfg_shift.shift.count;
        for (ln = 0; ln < int'(cfg_lines[14:0]); ln++) begin
            prev_a = '0;                    // zero nibbles enter at each line start
            prev_b = '0;
            for (w = 0; w < int'(cfg_words); w++) begin
                a = cfg_src_a;
                b = cfg_src_b;
                if (!cfg_ctrl.ctrl.a_const) begin
                    ra = ref_mem[pa[11:0]];
                    a = word_t'({prev_a, ra} >> (4 * sh));
                    prev_a = ra;
                    pa++;
                end
                if (!cfg_ctrl.ctrl.b_const) begin
                    rb = ref_mem[pb[11:0]];
                    b = word_t'({prev_b, rb} >> (4 * sh));
                    prev_b = rb;
                    pb++;
                end
                d = (a & (cfg_ctrl.ctrl.b_not ? ~b : b)) ^ (cfg_ctrl.ctrl.c_use_b ? b : cfg_val_c);
                for (n = 0; n < 4; n++) begin
                    if (cfg_ctrl.ctrl.transp_8b) begin
                        keep = (b[8*(n/2) +: 8] != cfg_ctrl.ctrl.transp_t);
                    end else begin
                        keep = (b[4*n +: 4] != cfg_ctrl.ctrl.transp_t[4*(n%2) +: 4]);
                    end
                    if (w == 0 && !cfg_shift.shift.l_mask[n]) keep = 1'b0;
                    if (w == int'(cfg_words) - 1 && !cfg_shift.shift.r_mask[n]) keep = 1'b0;
                    if (keep) begin
                        ref_mem[pd[11:0]][4*n +: 4] = d[4*n +: 4];
                    end
                end
                pd++;
            end
            pa += cfg_mod_a;
            pb += cfg_mod_b;
            pd += cfg_mod_d;
        end
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (done_count < target) begin
            $display("no done pulse from the blitter within %0d cycles at %0t", cycles, $time);
            errors++;
        end
    endtask

    task automatic compare_mem();
        int i;
        for (i = 0; i < 4096; i++) begin
            check_word($sformatf("mem[%03h]", i), mem[i], ref_mem[i]);
        end
    endtask

    task automatic run_blit();
        int base;
        base = done_count;
        model_blit();
        start_blit();
        wait_done(base + 1);
        @(negedge clk);
        check_flag("blit_busy_o", busy, 1'b0);
        check_flag("blit_full_o", full, 1'b0);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic run_copy();
        int e;
        e = errors;
        ref_mem = mem;
        check_flag("blit_busy_o", busy, 1'b0);
        check_flag("blit_full_o", full, 1'b0);
        check_flag("blit_done_intr_o", done, 1'b0);
        check_flag("blit_vram_sel_o", vram_sel, 1'b0);
        check_flag("blit_wr_o", vram_wr, 1'b0);
        configure_blit(16'h0002, 16'hff00, 16'h0100, 0, 16'hffff, 0, 0, 16'h0200, 0, 1, 8);
        run_blit();
        compare_mem();
        report_test("copy", e);
    endtask

    task automatic run_fill();
        int e;
        e = errors;
        ref_mem = mem;
        configure_blit(16'h0003, 16'hff00, 16'h3c5a, 0, 16'hf7fe, 0, 16'h1234, 16'h0300, 4, 3, 4);
        run_blit();
        compare_mem();
        report_test("rectangle fill", e);
    endtask

    task automatic run_shift();
        int e;
        e = errors;
        ref_mem = mem;
        configure_blit(16'h0002, 16'he301, 16'h0400, 3, 16'hffff, 0, 0, 16'h0500, 3, 2, 5);
        run_blit();
        configure_blit(16'h0002, 16'hbc02, 16'h0420, 3, 16'hffff, 0, 0, 16'h0540, 3, 2, 5);
        run_blit();
        compare_mem();
        report_test("shift with edge masks", e);
    endtask

    task automatic run_logic();
        int e;
        e = errors;
        ref_mem = mem;
        configure_blit(16'h0004, 16'hff00, 16'h0600, 2, 16'h0640, 2, 16'h0ff0, 16'h0680, 2, 2, 6);
        run_blit();                         // B inverted, both sources read
        configure_blit(16'h550a, 16'hff00, 16'h06c0, 0, 16'h5a05, 0, 16'hffff, 16'h06e0, 0, 1, 4);
        run_blit();                         // B in place of C, 4-bpp T
        configure_blit(16'h3c22, 16'hff00, 16'h0800, 0, 16'h3c71, 0, 16'h00f0, 16'h0820, 0, 1, 4);
        run_blit();                         // 8-bpp T hides the upper byte
        compare_mem();
        report_test("logic variants and transparency", e);
    endtask

    task automatic run_queue();
        int e, base;
        e = errors;
        base = done_count;
        ref_mem = mem;
        configure_blit(16'h0002, 16'hff00, 16'h0900, 2, 16'hffff, 0, 16'h0f0f, 16'h0a00, 2, 3, 6);
        model_blit();
        start_blit();
        @(negedge clk);
        check_flag("blit_full_o", full, 1'b1);
        configure_blit(16'h0001, 16'hff00, 16'hc3c3, 0, 16'h0b00, 0, 16'h5555, 16'h0b40, 0, 1, 4);
        model_blit();
        start_blit();
        @(negedge clk);
        check_flag("blit_full_o", full, 1'b1);
        check_flag("blit_busy_o", busy, 1'b1);
        wait_done(base + 1);
        @(negedge clk);                     // SETUP of the queued blit
        check_flag("blit_full_o", full, 1'b1);
        check_flag("blit_busy_o", busy, 1'b1);
        @(negedge clk);
        check_flag("blit_full_o", full, 1'b0);
        wait_done(base + 2);
        @(negedge clk);
        check_flag("blit_busy_o", busy, 1'b0);
        repeat (10) @(negedge clk);
        check_flag("exactly two done pulses", done_count == base + 2, 1'b1);
        compare_mem();
        report_test("queue", e);
    endtask

    initial begin : watchdog
        #((WORDS_TOTAL * 200 + 2000) * CLK_PERIOD);
        $display("watchdog expired at %0t, the blitter did not finish", $time);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        reset_i    = 1'b1;
        xreg_wr_en = 1'b0;
        xreg_num   = '0;
        xreg_data  = '0;
        vram_ack   = 1'b0;
        vram_rdata = '0;
        in_txn     = 1'b0;
        wait_left  = 0;
        done_count = 0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        lfsr_state = 32'hd5c934d2;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = word_t'(i * 40503) ^ 16'h1d2c;     // odd multiplier, distinct words
        end
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;
        run_copy();
        run_fill();
        run_shift();
        run_logic();
        run_queue();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
verilog/blit_pkg.sv
verilog/blit_regs.sv
verilog/blit_nibble_shift.sv
verilog/blit_datapath.sv
verilog/blit_sequencer.sv
verilog/blitter.sv
test/blitter_chk.sv
test/blitter_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the blitter testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module blitter_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vblitter_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
